// ==== design/dprx_pkg.sv ====
package dprx_pkg;

    // Symbols per clock on the lane
    localparam int SPL = 2;

    // K flag above the byte
    typedef logic [8:0] sym_t;

    // Scrambler reset in SST
    localparam sym_t SYM_K28_0 = 9'h11C;
    // BS, also scrambler reset in MST
    localparam sym_t SYM_K28_5 = 9'h1BC;

    // MST control index table
    localparam sym_t SYM_K23_7 = 9'h1F7;
    localparam sym_t SYM_K27_7 = 9'h1FB;
    localparam sym_t SYM_K28_2 = 9'h15C;
    localparam sym_t SYM_K28_3 = 9'h17C;
    localparam sym_t SYM_K28_6 = 9'h1DC;
    localparam sym_t SYM_K29_7 = 9'h1FD;
    localparam sym_t SYM_K30_7 = 9'h1FE;

    // LFSR restart value
    localparam logic [15:0] LFSR_SEED = 16'hFFFF;

    // One link beat
    typedef struct packed {
        logic               lock;
        sym_t [SPL-1:0]     sym;
    } lnk_beat_t;

    // Watchdog reload, short enough for simulation
    localparam int WDG_LOAD = 511;
    localparam int WDG_W    = $clog2(WDG_LOAD + 1);

    // SR event counter width
    localparam int SR_CNT_W = 16;

    // APB request
    typedef struct packed {
        logic               psel;
        logic               penable;
        logic               pwrite;
        logic [7:0]         paddr;
        logic [31:0]        pwdata;
    } apb_req_t;

    // APB response
    typedef struct packed {
        logic [31:0]        prdata;
        logic               pready;
        logic               pslverr;
    } apb_rsp_t;

    // Register map
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_STATUS = 8'h04;
    localparam logic [7:0] REG_SR_CNT = 8'h08;

    // Lock FSM states
    typedef enum logic [1:0] {
        ST_DISABLED,
        ST_HUNT,
        ST_LOCKED
    } lock_state_t;

endpackage

// ==== design/dprx_sr_watchdog.sv ====
`timescale 1ns/1ps

module dprx_sr_watchdog
(
    input  logic    CLK_IN,
    input  logic    RST_IN,
    input  logic    load,
    input  logic    run,
    output logic    expired
);

    import dprx_pkg::*;

    logic [WDG_W-1:0] cnt;

    // Down counter, stops at zero
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            cnt <= '0;
        // Reload wins over hold
        else if (load)
            cnt <= WDG_W'(WDG_LOAD);
        // Parked at zero while idle
        else if (!run)
            cnt <= '0;
        else if (!expired)
            cnt <= cnt - 1'b1;
    end

    assign expired = (cnt == '0);

endmodule

// ==== design/dprx_lock_fsm.sv ====
`timescale 1ns/1ps

module dprx_lock_fsm
(
    input  logic    CLK_IN,
    input  logic    RST_IN,
    input  logic    en,
    input  logic    in_lock,
    input  logic    sr_seen,
    input  logic    expired,
    output logic    wdg_load,
    output logic    wdg_run,
    output logic    lock,
    output logic    lost_pulse
);

    import dprx_pkg::*;

    lock_state_t    state;
    lock_state_t    state_nxt;
    logic           lost_nxt;

    // SR with input lock reloads the watchdog, in hunt or locked
    assign wdg_load = sr_seen && in_lock && (state != ST_DISABLED);
    assign wdg_run  = (state == ST_LOCKED) && in_lock;

    // Disabled reports locked, hunt does not
    assign lock = (state != ST_HUNT);

    always_comb
    begin
        state_nxt = state;
        lost_nxt  = 1'b0;
        if (!en)
            state_nxt = ST_DISABLED;
        else
        begin
            case (state)
                ST_DISABLED : state_nxt = ST_HUNT;
                ST_HUNT :
                begin
                    if (sr_seen && in_lock)
                        state_nxt = ST_LOCKED;
                end
                ST_LOCKED :
                begin
                    // Lane lost or no SR before timeout
                    if (!in_lock || (!sr_seen && expired))
                    begin
                        state_nxt = ST_HUNT;
                        lost_nxt  = 1'b1;
                    end
                end
                default : state_nxt = ST_HUNT;
            endcase
        end
    end

    // Reset parks in hunt so lock stays low until the first clock
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            state      <= ST_HUNT;
            lost_pulse <= 1'b0;
        end
        else
        begin
            state      <= state_nxt;
            lost_pulse <= lost_nxt;
        end
    end

endmodule

// ==== design/dprx_apb_regs.sv ====
`timescale 1ns/1ps

module dprx_apb_regs
(
    input  logic                    CLK_IN,
    input  logic                    RST_IN,
    input  dprx_pkg::apb_req_t      apb_req,
    output dprx_pkg::apb_rsp_t      apb_rsp,
    input  logic                    sr_seen,
    input  logic                    lock,
    input  logic                    lost_pulse,
    output logic                    en,
    output logic                    mst
);

    import dprx_pkg::*;

    logic                   access;
    logic                   addr_hit;
    logic                   wr_en;
    logic                   lost_clr;
    logic                   lost;
    logic [SR_CNT_W-1:0]    sr_cnt;

    // Access phase only, no wait states
    assign access   = apb_req.psel && apb_req.penable;
    assign addr_hit = apb_req.paddr inside {REG_CTRL, REG_STATUS, REG_SR_CNT};
    assign wr_en    = access && apb_req.pwrite && addr_hit;

    // Write one to clear
    assign lost_clr = wr_en && (apb_req.paddr == REG_STATUS) && apb_req.pwdata[1];

    // Control register
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            en  <= 1'b0;
            mst <= 1'b0;
        end
        else if (wr_en && (apb_req.paddr == REG_CTRL))
        begin
            en  <= apb_req.pwdata[0];
            mst <= apb_req.pwdata[1];
        end
    end

    // Sticky lost, set beats clear
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            lost <= 1'b0;
        else if (lost_pulse)
            lost <= 1'b1;
        else if (lost_clr)
            lost <= 1'b0;
    end

    // SR events, saturating
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            sr_cnt <= '0;
        else if (sr_seen && !(&sr_cnt))
            sr_cnt <= sr_cnt + 1'b1;
    end

    // Read mux
    always_comb
    begin
        apb_rsp.prdata = '0;
        if (access && !apb_req.pwrite)
        begin
            case (apb_req.paddr)
                REG_CTRL   : apb_rsp.prdata = {30'b0, mst, en};
                REG_STATUS : apb_rsp.prdata = {30'b0, lost, lock};
                REG_SR_CNT : apb_rsp.prdata = {{(32-SR_CNT_W){1'b0}}, sr_cnt};
                default    : apb_rsp.prdata = '0;
            endcase
        end
        apb_rsp.pready  = 1'b1;
        // Unmapped address
        apb_rsp.pslverr = access && !addr_hit;
    end

endmodule

// ==== design/dprx_descrambler.sv ====
`timescale 1ns/1ps

module dprx_descrambler
(
    input  logic                    CLK_IN,
    input  logic                    RST_IN,
    input  logic                    en,
    input  logic                    mst,
    input  logic                    lock,
    input  dprx_pkg::lnk_beat_t     lnk_in,
    output dprx_pkg::lnk_beat_t     lnk_out,
    output logic                    sr_seen
);

    import dprx_pkg::*;

    // Advance the scrambler by one byte, Galois form, 8 single shifts
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        logic        fb;
        n = s;
        for (int b = 0; b < 8; b++)
        begin
            fb = n[15];
            // Taps at x5, x4 and x3
            n  = {n[14:0], fb} ^ {10'b0, fb, fb, fb, 3'b0};
        end
        return n;
    endfunction

    // Key byte is the high byte, bit order reversed
    function automatic logic [7:0] key_byte(input logic [15:0] s);
        logic [7:0] k;
        for (int j = 0; j < 8; j++)
        begin
            k[j] = s[15-j];
        end
        return k;
    endfunction

    // Control symbol to table index, top bit flags a hit
    function automatic logic [3:0] ctl_index(input sym_t s);
        case (s)
            SYM_K23_7 : return 4'b1_000;
            SYM_K27_7 : return 4'b1_001;
            SYM_K28_0 : return 4'b1_010;
            SYM_K28_2 : return 4'b1_011;
            SYM_K28_3 : return 4'b1_100;
            SYM_K28_6 : return 4'b1_101;
            SYM_K29_7 : return 4'b1_110;
            SYM_K30_7 : return 4'b1_111;
            default   : return 4'b0_000;
        endcase
    endfunction

    // Table index back to control symbol
    function automatic sym_t ctl_symbol(input logic [2:0] idx);
        case (idx)
            3'd0    : return SYM_K23_7;
            3'd1    : return SYM_K27_7;
            3'd2    : return SYM_K28_0;
            3'd3    : return SYM_K28_2;
            3'd4    : return SYM_K28_3;
            3'd5    : return SYM_K28_6;
            3'd6    : return SYM_K29_7;
            default : return SYM_K30_7;
        endcase
    endfunction

    logic [SPL-1:0]     sr_det;
    logic [15:0]        lfsr_sym [SPL];
    logic [15:0]        lfsr_q;
    logic               sr_last_q;
    sym_t [SPL-1:0]     sym_nxt;

    // SR code depends on mode
    always_comb
    begin
        for (int i = 0; i < SPL; i++)
        begin
            sr_det[i] = (lnk_in.sym[i] == (mst ? SYM_K28_5 : SYM_K28_0));
        end
    end

    assign sr_seen = |sr_det;

    // LFSR chain and per-symbol output
    always_comb
    begin : chain
        logic [15:0] st;
        logic        rst;
        logic [3:0]  ctl;
        sym_t        s;
        st  = lfsr_q;
        // SR in last slot of previous beat restarts slot 0
        rst = sr_last_q;
        for (int i = 0; i < SPL; i++)
        begin
            lfsr_sym[i] = rst ? LFSR_SEED : lfsr_step(st);
            st          = lfsr_sym[i];
            rst         = sr_det[i];

            s   = lnk_in.sym[i];
            ctl = ctl_index(s);
            if (s[8])
            begin
                // MST control recovery through the index table
                if (en && mst && ctl[3])
                    sym_nxt[i] = ctl_symbol(ctl[2:0] ^
                                 {lfsr_sym[i][13], lfsr_sym[i][14], lfsr_sym[i][15]});
                // SST SR shows up as BS
                else if (!mst && (s == SYM_K28_0))
                    sym_nxt[i] = SYM_K28_5;
                else
                    sym_nxt[i] = s;
            end
            // Data byte
            else if (en)
                sym_nxt[i] = {1'b0, s[7:0] ^ key_byte(lfsr_sym[i])};
            else
                sym_nxt[i] = s;
        end
    end

    // LFSR state carried between beats, output beat registered
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            lfsr_q    <= LFSR_SEED;
            sr_last_q <= 1'b0;
            lnk_out   <= '0;
        end
        else
        begin
            lfsr_q       <= lfsr_sym[SPL-1];
            sr_last_q    <= sr_det[SPL-1];
            lnk_out.lock <= lock;
            lnk_out.sym  <= sym_nxt;
        end
    end

endmodule

// ==== design/dprx_scrm_top.sv ====
`timescale 1ns/1ps

module dprx_scrm_top
(
    input  logic                    CLK_IN,
    input  logic                    RST_IN,
    input  dprx_pkg::apb_req_t      apb_req,
    output dprx_pkg::apb_rsp_t      apb_rsp,
    input  dprx_pkg::lnk_beat_t     lnk_in,
    output dprx_pkg::lnk_beat_t     lnk_out,
    output logic                    lock
);

    logic   en;
    logic   mst;
    logic   sr_seen;
    logic   lost_pulse;
    logic   wdg_load;
    logic   wdg_run;
    logic   expired;

    // Register block
    dprx_apb_regs u_regs
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .sr_seen    (sr_seen),
        .lock       (lock),
        .lost_pulse (lost_pulse),
        .en         (en),
        .mst        (mst)
    );

    // Lock tracking, input lock comes with the beat
    dprx_lock_fsm u_fsm
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .en         (en),
        .in_lock    (lnk_in.lock),
        .sr_seen    (sr_seen),
        .expired    (expired),
        .wdg_load   (wdg_load),
        .wdg_run    (wdg_run),
        .lock       (lock),
        .lost_pulse (lost_pulse)
    );

    // SR timeout
    dprx_sr_watchdog u_wdg
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .load       (wdg_load),
        .run        (wdg_run),
        .expired    (expired)
    );

    // Datapath
    dprx_descrambler u_dscr
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .en         (en),
        .mst        (mst),
        .lock       (lock),
        .lnk_in     (lnk_in),
        .lnk_out    (lnk_out),
        .sr_seen    (sr_seen)
    );

endmodule

// ==== verif/dprx_scrm_tb.sv ====
`timescale 1ns/1ps

module dprx_scrm_tb;

    import dprx_pkg::*;

    logic           CLK_IN;
    logic           RST_IN;
    apb_req_t       apb_req;
    apb_rsp_t       apb_rsp;
    lnk_beat_t      lnk_in;
    lnk_beat_t      lnk_out;
    logic           lock;

    // Stimulus mix: 0 any, 1 SST, 2 MST, 3 no MST SR
    int             beat_kind;
    int             seed;
    int             cycles;
    int             cycle_limit;
    int             len_disabled;
    int             len_sst;
    int             len_mst;
    string          phase;
    apb_rsp_t       rsp_cap;
    logic [31:0]    exp_rd;

    // Reference model state
    lock_state_t    state_m;
    int             wdg_m;
    logic [15:0]    lfsr_m;
    logic           rst_pend_m;
    logic           en_m;
    logic           mst_m;
    logic           lost_m;
    logic           pulse_m;
    logic [15:0]    cnt_m;

    // MST index table, K28.0 at index 2
    sym_t ctl_table [8] = '{SYM_K23_7, SYM_K27_7, SYM_K28_0, SYM_K28_2,
                            SYM_K28_3, SYM_K28_6, SYM_K29_7, SYM_K30_7};

    dprx_scrm_top UUT
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .lnk_in     (lnk_in),
        .lnk_out    (lnk_out),
        .lock       (lock)
    );

    initial
    begin
        CLK_IN = 1'b0;
        forever #4 CLK_IN = ~CLK_IN;
    end

    // Run limit
    always @(posedge CLK_IN)
    begin
        cycles++;
        if (cycles >= cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            fail_run();
        end
    end

    task automatic fail_run();
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_beat(input string what, input lnk_beat_t exp, input lnk_beat_t act);
        if (exp !== act)
        begin
            $display("ERROR [%s] %s: expected %h, actual %h", phase, what, exp, act);
            fail_run();
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
        if (exp !== act)
        begin
            $display("ERROR [%s] %s: expected %h, actual %h", phase, what, exp, act);
            fail_run();
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("ERROR [%s] %s: expected %b, actual %b", phase, what, exp, act);
            fail_run();
        end
    endtask

    // x16+x5+x4+x3+1, one byte per call, MSB first
    function automatic logic [15:0] lfsr_advance(input logic [15:0] s);
        logic [15:0] v;
        v = s;
        repeat (8)
            v = v[15] ? ((v << 1) ^ 16'h0039) : (v << 1);
        return v;
    endfunction

    // Scrambling byte is the LFSR high byte, bit reversed
    function automatic logic [7:0] key_of(input logic [15:0] s);
        logic [7:0] k;
        for (int j = 0; j < 8; j++)
            k[7-j] = s[8+j];
        return k;
    endfunction

    function automatic sym_t rand_sym();
        logic [31:0] r;
        r = $random(seed);
        case (beat_kind)
            0 : return (r[3:0] < 2) ? SYM_K28_0 : (r[3:0] == 2) ? SYM_K28_5 :
                       (r[3:0] < 5) ? ctl_table[r[10:8]] : {1'b0, r[23:16]};
            1 : return (r[3:0] < 2) ? SYM_K28_0 : (r[3:0] == 2) ? ctl_table[r[10:8]] :
                       {1'b0, r[23:16]};
            2 : return (r[3:0] < 2) ? SYM_K28_5 : (r[3:0] < 4) ? ctl_table[r[10:8]] :
                       {1'b0, r[23:16]};
            default : return (r[3:0] == 0) ? ctl_table[r[10:8]] : {1'b0, r[23:16]};
        endcase
    endfunction

    // Expected output symbol for one input symbol and its LFSR state
    function automatic sym_t expect_sym(input sym_t s, input logic [15:0] cur);
        int idx;
        idx = -1;
        if (!s[8])
            return en_m ? {1'b0, s[7:0] ^ key_of(cur)} : s;
        for (int i = 0; i < 8; i++)
            if (s == ctl_table[i])
                idx = i;
        if (en_m && mst_m && (idx >= 0))
            return ctl_table[3'(idx) ^ {cur[13], cur[14], cur[15]}];
        if (!mst_m && (s == SYM_K28_0))
            return SYM_K28_5;
        return s;
    endfunction

    function automatic logic [31:0] read_model(input logic [7:0] addr);
        case (addr)
            REG_CTRL   : return {30'b0, mst_m, en_m};
            REG_STATUS : return {30'b0, lost_m, (state_m != ST_HUNT)};
            REG_SR_CNT : return {16'b0, cnt_m};
            default    : return 32'b0;
        endcase
    endfunction

    task automatic predict_beat(input lnk_beat_t b, output lnk_beat_t e, output logic sr);
        logic [15:0] cur;
        sym_t        sr_code;
        sr_code = mst_m ? SYM_K28_5 : SYM_K28_0;
        sr      = 1'b0;
        // Output lock is the lock seen at the sampling edge
        e.lock  = (state_m != ST_HUNT);
        for (int i = 0; i < SPL; i++)
        begin
            cur        = rst_pend_m ? LFSR_SEED : lfsr_advance(lfsr_m);
            lfsr_m     = cur;
            rst_pend_m = (b.sym[i] == sr_code);
            sr         = sr | rst_pend_m;
            e.sym[i]   = expect_sym(b.sym[i], cur);
        end
    endtask

    // Model state after one clock edge, input lock always high
    task automatic advance_model(input apb_req_t r, input logic sr);
        lock_state_t nxt;
        logic        lost_n;
        logic        wr;
        nxt    = state_m;
        lost_n = 1'b0;
        wr     = r.psel && r.penable && r.pwrite;
        if (!en_m)
            nxt = ST_DISABLED;
        else if (state_m == ST_DISABLED)
            nxt = ST_HUNT;
        else if (state_m == ST_HUNT)
            nxt = sr ? ST_LOCKED : ST_HUNT;
        else if (!sr && (wdg_m == 0))
        begin
            nxt    = ST_HUNT;
            lost_n = 1'b1;
        end
        if (sr && (state_m != ST_DISABLED))
            wdg_m = WDG_LOAD;
        else if (state_m != ST_LOCKED)
            wdg_m = 0;
        else if (wdg_m != 0)
            wdg_m--;
        if (pulse_m)
            lost_m = 1'b1;
        else if (wr && (r.paddr == REG_STATUS) && r.pwdata[1])
            lost_m = 1'b0;
        pulse_m = lost_n;
        if (sr && (cnt_m != 16'hFFFF))
            cnt_m = cnt_m + 16'd1;
        if (wr && (r.paddr == REG_CTRL))
        begin
            en_m  = r.pwdata[0];
            mst_m = r.pwdata[1];
        end
        state_m = nxt;
    endtask

    // One clock: drive on the falling edge, check on the next one
    task automatic step(input apb_req_t r);
        lnk_beat_t b;
        lnk_beat_t exp_b;
        logic      sr;
        b.lock   = 1'b1;
        b.sym[0] = rand_sym();
        b.sym[1] = rand_sym();
        apb_req  = r;
        lnk_in   = b;
        predict_beat(b, exp_b, sr);
        exp_rd   = read_model(r.paddr);
        #2;
        rsp_cap  = apb_rsp;
        @(negedge CLK_IN);
        check_beat("lnk_out", exp_b, lnk_out);
        advance_model(r, sr);
        check_bit("lock", (state_m != ST_HUNT), lock);
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        apb_req_t r;
        r        = '0;
        r.psel   = 1'b1;
        r.pwrite = 1'b1;
        r.paddr  = addr;
        r.pwdata = data;
        step(r);
        r.penable = 1'b1;
        step(r);
        check_bit("write pslverr", 1'b0, rsp_cap.pslverr);
        check_bit("write pready", 1'b1, rsp_cap.pready);
    endtask

    task automatic apb_read(input string what, input logic [7:0] addr, input logic err);
        apb_req_t r;
        r       = '0;
        r.psel  = 1'b1;
        r.paddr = addr;
        step(r);
        r.penable = 1'b1;
        step(r);
        check_word(what, exp_rd, rsp_cap.prdata);
        check_bit({what, " pslverr"}, err, rsp_cap.pslverr);
        check_bit({what, " pready"}, 1'b1, rsp_cap.pready);
    endtask

    initial
    begin
        seed         = 32'he67dc1e2;
        cycles       = 0;
        len_disabled = 1400;
        len_sst      = 2000;
        len_mst      = 2000;
        // Twice the phases, loss phase runs past the watchdog
        cycle_limit  = 2 * (len_disabled + len_sst + len_mst + WDG_LOAD + 76);
        beat_kind    = 0;
        phase        = "reset";
        RST_IN       = 1'b1;
        apb_req      = '0;
        lnk_in       = '0;
        state_m      = ST_HUNT;
        wdg_m        = 0;
        lfsr_m       = LFSR_SEED;
        rst_pend_m   = 1'b0;
        en_m         = 1'b0;
        mst_m        = 1'b0;
        lost_m       = 1'b0;
        pulse_m      = 1'b0;
        cnt_m        = '0;
        repeat (16) @(posedge CLK_IN);
        @(negedge CLK_IN);
        check_beat("lnk_out in reset", '0, lnk_out);
        check_bit("lock in reset", 1'b0, lock);
        check_bit("pslverr in reset", 1'b0, apb_rsp.pslverr);
        RST_IN = 1'b0;

        phase = "disabled";
        repeat (len_disabled) step('0);
        check_bit("lock while disabled", 1'b1, lock);

        phase     = "sst";
        beat_kind = 1;
        apb_write(REG_CTRL, 32'h1);
        repeat (len_sst) step('0);
        check_bit("lock after SST SRs", 1'b1, lock);

        phase     = "mst";
        beat_kind = 2;
        apb_write(REG_CTRL, 32'h3);
        repeat (len_mst) step('0);
        check_bit("lock after MST SRs", 1'b1, lock);

        // SRs stop, watchdog runs out
        phase     = "lock loss";
        beat_kind = 3;
        repeat (WDG_LOAD + 8) step('0);
        check_bit("lock after SR gap", 1'b0, lock);
        apb_read("STATUS lost set", REG_STATUS, 1'b0);
        check_word("lost bit", 32'h2, rsp_cap.prdata);
        apb_write(REG_STATUS, 32'h2);
        apb_read("STATUS lost cleared", REG_STATUS, 1'b0);
        check_word("lost cleared", 32'h0, rsp_cap.prdata);
        beat_kind = 2;
        repeat (20) step('0);
        check_bit("relock", 1'b1, lock);

        phase = "registers";
        apb_read("CTRL", REG_CTRL, 1'b0);
        check_word("CTRL readback", 32'h3, rsp_cap.prdata);
        apb_write(REG_CTRL, 32'h1);
        apb_read("CTRL", REG_CTRL, 1'b0);
        check_word("CTRL readback", 32'h1, rsp_cap.prdata);
        apb_read("SR_CNT", REG_SR_CNT, 1'b0);
        apb_read("STATUS", REG_STATUS, 1'b0);
        apb_read("unmapped", 8'h0C, 1'b1);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== tb.f ====
design/dprx_pkg.sv
design/dprx_sr_watchdog.sv
design/dprx_lock_fsm.sv
design/dprx_apb_regs.sv
design/dprx_descrambler.sv
design/dprx_scrm_top.sv
verif/dprx_scrm_tb.sv

// ==== Makefile ====
SRCS := $(wildcard design/*.sv) $(wildcard verif/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vdprx_scrm_tb: tb.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module dprx_scrm_tb \
		-f tb.f -o Vdprx_scrm_tb

# The log decides pass or fail
run: obj_dir/Vdprx_scrm_tb
	-./obj_dir/Vdprx_scrm_tb > sim.log 2>&1
	@cat sim.log
	@grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
